// ==== binCounter.sv ====
`timescale 1ns/1ns

module binCounter #(
    parameter int Nb = histPkg::NB_DEF,
    parameter int PixelNum = histPkg::PIXEL_NUM_DEF,
    parameter int CntW = histPkg::CNT_W_DEF
) (
    input logic clk,
    input logic combin_res,
    binBus.dst bi,
    input logic clear,
    countBus.src co
);
    localparam int BinNum = 1 << Nb;
    localparam int Depth = PixelNum * BinNum;
    localparam int AddrW = (Depth > 1) ? $clog2(Depth) : 1;

    logic [CntW-1:0] countMem [Depth];
    logic [Depth-1:0] binValid;                 // bin holds a count from this frame
    logic [AddrW-1:0] rdAddr;
    logic [AddrW-1:0] wrAddr;
    logic hitQ;
    logic fwd;
    logic [CntW-1:0] base;
    logic [CntW-1:0] nextCount;

    assign rdAddr = AddrW'({bi.pixel, bi.bin});
    assign wrAddr = AddrW'({co.pixel, co.bin});

    // memory is written from the output stage, so that write is still pending
    assign fwd = co.valid && hitQ && (wrAddr == rdAddr);
    assign base = fwd ? co.count : (binValid[rdAddr] ? countMem[rdAddr] : '0);
    assign nextCount = bi.hit ? base + 1'b1 : '0;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            co.valid <= 1'b0;
            co.last <= 1'b0;
            hitQ <= 1'b0;
            binValid <= '0;
        end else begin
            co.valid <= bi.valid;
            co.last <= bi.valid && bi.last;
            hitQ <= bi.valid && bi.hit;
            if (clear) begin
                binValid <= '0;                 // whole histogram in one cycle
            end else if (co.valid && hitQ) begin
                binValid[wrAddr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bi.valid) begin
            co.pixel <= bi.pixel;
            co.bin <= bi.bin;
            co.count <= nextCount;
            co.pass <= bi.pass;
        end
        if (co.valid && hitQ) begin
            countMem[wrAddr] <= co.count;
        end
    end

    noOverflow: assert property (@(posedge clk) disable iff (!combin_res)
        bi.valid && bi.hit |-> base != '1);

    // clear lands inside the idle gap that follows a frame end
    frameGap: assert property (@(posedge clk) disable iff (!combin_res)
        bi.valid && bi.last |=> !bi.valid [*3]);

    noHitOnClear: assert property (@(posedge clk) disable iff (!combin_res)
        clear |-> !bi.valid);

endmodule

// ==== files.f ====
histPkg.sv
histBus.sv
sampleWindow.sv
binCounter.sv
peakTracker.sv
hisBuilderTop.sv
tbHisBuilder.sv

// ==== hisBuilderTop.sv ====
`timescale 1ns/1ns

module hisBuilderTop #(
    parameter int Np = histPkg::NP_DEF,
    parameter int Nb = histPkg::NB_DEF,
    parameter int PixelNum = histPkg::PIXEL_NUM_DEF,
    parameter int DataNum = histPkg::DATA_NUM_DEF,
    parameter int AcqNum = histPkg::ACQ_NUM_DEF,
    parameter int CntW = histPkg::CNT_W_DEF,
    localparam int PixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic [Np-1:0] data,
    input  logic [PixW-1:0] rdPixel,
    output logic frameDone,
    output histPkg::passT pass,
    output logic [Nb-1:0] rdCoarse,
    output logic [Np-1:0] rdFine
);
    logic [PixW-1:0] winPixel;
    logic [Np-1:0] winLo;
    logic clear;

    binBus #(.Nb(Nb), .PixelNum(PixelNum)) binLink ();
    countBus #(.Nb(Nb), .PixelNum(PixelNum), .CntW(CntW)) countLink ();

    sampleWindow #(
        .Np(Np), .Nb(Nb), .PixelNum(PixelNum), .DataNum(DataNum), .AcqNum(AcqNum)
    ) sampler (
        .clk(clk),
        .combin_res(combin_res),
        .wrEn(wrEn),
        .data(data),
        .winPixel(winPixel),
        .winLo(winLo),                          // fine window of the current pixel
        .pass(pass),
        .bo(binLink.src)
    );

    binCounter #(.Nb(Nb), .PixelNum(PixelNum), .CntW(CntW)) counter (
        .clk(clk),
        .combin_res(combin_res),
        .bi(binLink.dst),
        .clear(clear),
        .co(countLink.src)
    );

    peakTracker #(.Np(Np), .Nb(Nb), .PixelNum(PixelNum), .CntW(CntW)) tracker (
        .clk(clk),
        .combin_res(combin_res),
        .ci(countLink.dst),
        .winPixel(winPixel),
        .winLo(winLo),
        .clear(clear),
        .frameDone(frameDone),
        .rdPixel(rdPixel),
        .rdCoarse(rdCoarse),
        .rdFine(rdFine)
    );

endmodule

// ==== hisBuilder_golden.txt ====
# S: one acquisition in hex, DATA_NUM samples per pixel, pixel 0 first
# E: pixel, expected rdCoarse (coarse frame) or rdFine (fine frame) in hex, pass after frame
S 005 00A 1F4 010 3F0 3E5 100 3FF 0C8 140 145 0CF 225 230 080 23F
S 3E0 01C 2A0 050 3E8 104 108 000 14A 0D0 200 210 081 082 228 3A0
E 0 00 1
E 1 1F 1
E 2 0A 1
E 3 11 1
S 007 300 300 300 3E2 3F5 3F5 3E2 140 141 141 12F 220 220 215 215
S 007 300 012 300 3D0 3F5 3E2 3D0 150 14F 14F 14F 215 220 100 3FF
E 0 007 0
E 1 3E2 0
E 2 14F 0
E 3 215 0
S 285 290 000 29F 110 111 3E0 112 320 330 33F 0C8 090 091 092 230
S 281 3F0 000 010 113 3E1 3E2 020 0C9 0CA 321 140 231 093 380 3C0
E 0 14 1
E 1 08 1
E 2 19 1
E 3 04 1
S 27A 27A 28F 290 0F8 100 100 0EF 000 000 000 325 070 075 075 08F
S 270 27A 26F 28F 110 0F8 100 0F8 3FF 3FF 000 000 08F 08F 090 06F
E 0 27A 0
E 1 100 0
E 2 325 0
E 3 08F 0

// ==== histBus.sv ====
`timescale 1ns/1ns

interface binBus #(
    parameter int Nb = histPkg::NB_DEF,
    parameter int PixelNum = histPkg::PIXEL_NUM_DEF,
    localparam int PixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
);
    import histPkg::*;

    logic valid;
    logic [PixW-1:0] pixel;
    logic [Nb-1:0] bin;
    logic hit;                   // low only for an out-of-window frame end
    logic last;                  // final sample of the frame
    passT pass;

    modport src (output valid, pixel, bin, hit, last, pass);
    modport dst (input valid, pixel, bin, hit, last, pass);
endinterface

interface countBus #(
    parameter int Nb = histPkg::NB_DEF,
    parameter int PixelNum = histPkg::PIXEL_NUM_DEF,
    parameter int CntW = histPkg::CNT_W_DEF,
    localparam int PixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
);
    import histPkg::*;

    logic valid;
    logic [PixW-1:0] pixel;
    logic [Nb-1:0] bin;
    logic [CntW-1:0] count;      // zero when the sample was not binned
    logic last;
    passT pass;

    modport src (output valid, pixel, bin, count, last, pass);
    modport dst (input valid, pixel, bin, count, last, pass);
endinterface

// ==== histPkg.sv ====
package histPkg;

    localparam int NP_DEF = 10;           // sample width
    localparam int NB_DEF = 5;            // bin address width
    localparam int PIXEL_NUM_DEF = 4;
    localparam int DATA_NUM_DEF = 4;      // samples per pixel per acquisition
    localparam int ACQ_NUM_DEF = 2;       // acquisitions per frame
    localparam int CNT_W_DEF = 8;         // bin count width

    // coarse pass bins on the top bits, fine pass on full resolution
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } passT;

endpackage

// ==== peakTracker.sv ====
`timescale 1ns/1ns

module peakTracker #(
    parameter int Np = histPkg::NP_DEF,
    parameter int Nb = histPkg::NB_DEF,
    parameter int PixelNum = histPkg::PIXEL_NUM_DEF,
    parameter int CntW = histPkg::CNT_W_DEF,
    localparam int PixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  logic clk,
    input  logic combin_res,
    countBus.dst ci,
    input  logic [PixW-1:0] winPixel,
    output logic [Np-1:0] winLo,
    output logic clear,
    output logic frameDone,
    input  logic [PixW-1:0] rdPixel,
    output logic [Nb-1:0] rdCoarse,
    output logic [Np-1:0] rdFine
);
    import histPkg::*;

    localparam logic [Np:0] HalfW = 1 << (Nb - 1);
    localparam logic [Np:0] MaxLo = (1 << Np) - (1 << Nb);   // highest legal window start

    logic [CntW-1:0] maxCnt [PixelNum];
    logic [Nb-1:0] maxBin [PixelNum];
    logic [Nb-1:0] coarsePeak [PixelNum];
    logic [Np-1:0] finePeak [PixelNum];
    logic [Np-1:0] winLoReg [PixelNum];
    logic [Nb-1:0] finalBin [PixelNum];
    logic greater;

    // peak bin to sample units, less half a window, kept inside the range
    function automatic logic [Np-1:0] windowLo(input logic [Nb-1:0] peakBin);
        logic [Np:0] start;
        start = '0;
        start[Np-1 -: Nb] = peakBin;
        if (start < HalfW) begin
            return '0;
        end
        if (start - HalfW > MaxLo) begin
            return MaxLo[Np-1:0];
        end
        return Np'(start - HalfW);
    endfunction

    assign greater = ci.valid && (ci.count > maxCnt[ci.pixel]);   // strict, first to peak wins

    // peak bins including the item arriving now, used at frame end
    always_comb begin
        for (int p = 0; p < PixelNum; p++) begin
            finalBin[p] = (greater && int'(ci.pixel) == p) ? ci.bin : maxBin[p];
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frameDone <= 1'b0;
            for (int p = 0; p < PixelNum; p++) begin
                maxCnt[p] <= '0;
                maxBin[p] <= '0;
                coarsePeak[p] <= '0;
                finePeak[p] <= '0;
                winLoReg[p] <= '0;
            end
        end else begin
            frameDone <= ci.valid && ci.last;
            if (ci.valid && ci.last) begin
                for (int p = 0; p < PixelNum; p++) begin
                    maxCnt[p] <= '0;
                    maxBin[p] <= '0;
                    if (ci.pass == COARSE) begin
                        coarsePeak[p] <= finalBin[p];
                        winLoReg[p] <= windowLo(finalBin[p]);
                    end else begin
                        finePeak[p] <= winLoReg[p] + Np'(finalBin[p]);   // back to sample units
                    end
                end
            end else if (greater) begin
                maxCnt[ci.pixel] <= ci.count;
                maxBin[ci.pixel] <= ci.bin;
            end
        end
    end

    assign clear = frameDone;                   // histogram cleared with the frame end pulse
    assign winLo = winLoReg[winPixel];
    assign rdCoarse = coarsePeak[rdPixel];
    assign rdFine = finePeak[rdPixel];

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tbHisBuilder -f files.f &&
./obj_dir/VtbHisBuilder | tee /dev/stderr | grep -q "^Done: no errors$" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sampleWindow.sv ====
`timescale 1ns/1ns

module sampleWindow #(
    parameter int Np = histPkg::NP_DEF,
    parameter int Nb = histPkg::NB_DEF,
    parameter int PixelNum = histPkg::PIXEL_NUM_DEF,
    parameter int DataNum = histPkg::DATA_NUM_DEF,
    parameter int AcqNum = histPkg::ACQ_NUM_DEF,
    localparam int PixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic [Np-1:0] data,
    output logic [PixW-1:0] winPixel,
    input  logic [Np-1:0] winLo,
    output histPkg::passT pass,
    binBus.src bo
);
    import histPkg::*;

    localparam int DataW = (DataNum > 1) ? $clog2(DataNum) : 1;
    localparam int AcqW = (AcqNum > 1) ? $clog2(AcqNum) : 1;
    localparam logic [Np:0] WinW = 1 << Nb;     // fine window width in sample units

    logic [DataW-1:0] dataCnt;
    logic [PixW-1:0] pixelCnt;
    logic [AcqW-1:0] acqCnt;
    logic dataEnd;
    logic pixelEnd;
    logic lastSample;
    logic [Np:0] offset;
    logic inWin;
    logic [Nb-1:0] binSel;

    assign winPixel = pixelCnt;                 // window of the pixel being sampled
    assign dataEnd = (dataCnt == DataW'(DataNum - 1));
    assign pixelEnd = (pixelCnt == PixW'(PixelNum - 1));
    assign lastSample = dataEnd && pixelEnd && (acqCnt == AcqW'(AcqNum - 1));

    // extra top bit goes high when data is below winLo
    assign offset = {1'b0, data} - {1'b0, winLo};
    assign inWin = !offset[Np] && (offset < WinW);
    assign binSel = (pass == COARSE) ? data[Np-1 -: Nb] : offset[Nb-1:0];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            dataCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            pass <= COARSE;
        end else if (wrEn) begin
            if (dataEnd) begin
                dataCnt <= '0;
                if (pixelEnd) begin
                    pixelCnt <= '0;
                    if (acqCnt == AcqW'(AcqNum - 1)) begin
                        acqCnt <= '0;
                        pass <= (pass == COARSE) ? FINE : COARSE;   // frame end
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                dataCnt <= dataCnt + 1'b1;
            end
        end
    end

    // frame end is always forwarded, even when it falls outside the window
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bo.valid <= 1'b0;
            bo.last <= 1'b0;
        end else begin
            bo.valid <= wrEn && (inWin || (pass == COARSE) || lastSample);
            bo.last <= wrEn && lastSample;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            bo.pixel <= pixelCnt;
            bo.bin <= binSel;
            bo.hit <= inWin || (pass == COARSE);
            bo.pass <= pass;                    // pass of this sample, not the next
        end
    end

    pixelInRange: assert property (@(posedge clk) disable iff (!combin_res)
        int'(pixelCnt) < PixelNum);

endmodule

// ==== tbHisBuilder.sv ====
`timescale 1ns/1ns

module tbHisBuilder;
    import histPkg::*;

    localparam int PixW = (PIXEL_NUM_DEF > 1) ? $clog2(PIXEL_NUM_DEF) : 1;
    localparam int RowLen = PIXEL_NUM_DEF * DATA_NUM_DEF;     // samples per acquisition
    localparam int SampleTotal = 4 * ACQ_NUM_DEF * RowLen;    // two coarse/fine rounds
    localparam int CycleLimit = 8 * SampleTotal + 100;
    localparam int DoneLatency = 3;                           // wrEn clock to frameDone

    logic clk;
    logic combin_res;
    logic wrEn;
    logic [NP_DEF-1:0] data;
    logic [PixW-1:0] rdPixel;
    logic frameDone;
    passT passOut;
    logic [NB_DEF-1:0] rdCoarse;
    logic [NP_DEF-1:0] rdFine;
    int errCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int sampleCount = 0;
    logic [31:0] rngState = 32'd39990;

    hisBuilderTop #(
        .Np(NP_DEF), .Nb(NB_DEF), .PixelNum(PIXEL_NUM_DEF),
        .DataNum(DATA_NUM_DEF), .AcqNum(ACQ_NUM_DEF), .CntW(CNT_W_DEF)
    ) dut (
        .clk(clk),
        .combin_res(combin_res),
        .wrEn(wrEn),
        .data(data),
        .rdPixel(rdPixel),
        .frameDone(frameDone),
        .pass(passOut),
        .rdCoarse(rdCoarse),
        .rdFine(rdFine)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout after %0d cycles, frameDone never arrived", cycleCount);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // 0 to 3 idle cycles, then one sample
    task automatic sendSample(input logic [NP_DEF-1:0] value);
        int gap;
        rngState = lcgNext(rngState);
        gap = int'(rngState[17:16]);
        repeat (gap) begin
            @(posedge clk);
            #1 wrEn = 1'b0;
        end
        @(posedge clk);
        #1;
        wrEn = 1'b1;
        data = value;
        sampleCount++;
    endtask

    task automatic waitFrameDone();
        int waited;
        @(posedge clk);
        #1 wrEn = 1'b0;                               // quiet until the frame closes
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!frameDone);
        checkEq(waited, DoneLatency, "cycles from last sample to frameDone");
        @(negedge clk);
        checkEq(frameDone, 1'b0, "frameDone single cycle pulse");
    endtask

    task automatic checkPeak(input int pix, input logic [NP_DEF-1:0] expVal, input int expPass);
        @(posedge clk);
        #1 rdPixel = PixW'(pix);
        @(negedge clk);
        checkEq(passOut, expPass, "pass after frame");
        if (expPass == FINE) begin                   // coarse frame just ended
            checkEq(rdCoarse, expVal, $sformatf("pixel %0d rdCoarse", pix));
        end else begin
            checkEq(rdFine, expVal, $sformatf("pixel %0d rdFine", pix));
        end
    endtask

    initial begin
        int fd;
        int code;
        int rows;
        int pix;
        int expPass;
        logic [NP_DEF-1:0] value;
        logic [63:0] tag;
        logic [8*128-1:0] restOfLine;
        logic fileDone;
        clk = 1'b0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        rdPixel = '0;
        rows = 0;
        fileDone = 1'b0;
        repeat (5) @(posedge clk);
        #1 combin_res = 1'b1;
        checkEq(passOut, COARSE, "pass after reset");
        fd = $fopen("hisBuilder_golden.txt", "r");
        if (fd == 0) begin
            errCount++;
            $display("cannot open hisBuilder_golden.txt");
            fileDone = 1'b1;
        end
        while (!fileDone) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                fileDone = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(restOfLine, fd);        // column notes
            end else if (tag == "S") begin
                for (int i = 0; i < RowLen; i++) begin
                    code = $fscanf(fd, "%h", value);
                    sendSample(value);
                end
                rows++;
                if (rows == ACQ_NUM_DEF) begin
                    waitFrameDone();
                    rows = 0;
                end
            end else if (tag == "E") begin
                code = $fscanf(fd, "%d %h %d", pix, value, expPass);
                checkPeak(pix, value, expPass);
            end else begin
                errCount++;
                $display("golden file holds a line with an unknown tag");
                fileDone = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (sampleCount != SampleTotal) begin
            errCount++;
            $display("only %0d of %0d samples were sent", sampleCount, SampleTotal);
        end
        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
